//--- hw/bram_macros.svh
`ifndef BRAM_MACROS_SVH
`define BRAM_MACROS_SVH

// host side word and bank side datum widths
`define BRAM_IN_WIDTH   32
`define BRAM_OUT_WIDTH  16

// bank geometry, bank count is a power of two
`define BRAM_BANKS      4
`define BRAM_OUT_DEPTH  256

// data per host word, power of two and no more than the bank count
`define BRAM_LANES      (`BRAM_IN_WIDTH / `BRAM_OUT_WIDTH)

`define BRAM_OUT_ADDR   $clog2(`BRAM_OUT_DEPTH)   // bank address bits
`define BRAM_BANK_BITS  $clog2(`BRAM_BANKS)       // bank select bits
// word address bits, total data over lanes per word
`define BRAM_IN_ADDR    $clog2((`BRAM_BANKS * `BRAM_OUT_DEPTH) / `BRAM_LANES)

// one write enable per byte
`define BRAM_IN_WE      (`BRAM_IN_WIDTH / 8)
`define BRAM_OUT_WE     (`BRAM_OUT_WIDTH / 8)

`endif

//--- hw/bram_pkg.sv
`include "bram_macros.svh"

package bram_pkg;

  // data carried on each side of the translator
  typedef logic [`BRAM_IN_WIDTH-1:0]  word_t;   // host word
  typedef logic [`BRAM_OUT_WIDTH-1:0] datum_t;  // one bank entry

  // addressing
  typedef logic [`BRAM_IN_ADDR-1:0]   waddr_t;     // host word address
  typedef logic [`BRAM_OUT_ADDR-1:0]  baddr_t;     // address inside a bank
  typedef logic [`BRAM_BANK_BITS-1:0] bank_idx_t;  // which bank

  // byte enables, word wide and datum wide
  typedef logic [`BRAM_IN_WE-1:0]     wbe_t;
  typedef logic [`BRAM_OUT_WE-1:0]    dbe_t;

  typedef logic [`BRAM_BANKS-1:0]     bank_en_t;   // one bit per bank

  // port controller sequence, one command per pass
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,  // waiting for a strobe
    ST_ACCESS = 2'd1,  // banks enabled for this cycle
    ST_RESP   = 2'd2   // read data valid, done pulsed
  } ctrl_state_t;

endpackage

//--- hw/bram_bank.sv
`timescale 1ns/100ps
`include "bram_macros.svh"

// single bank of block RAM, byte writable, one cycle read latency
module bram_bank
  import bram_pkg::*;
(
  input  logic   clk_i,
  input  logic   en_i,     // bank selected this cycle
  input  dbe_t   we_i,     // per byte write enables
  input  baddr_t addr_i,
  input  datum_t wdata_i,
  output datum_t rdata_o   // registered, holds between accesses
);

  datum_t mem [`BRAM_OUT_DEPTH];  // storage, no reset like real BRAM
  datum_t rdata_q;

  // read returns old contents when the same address is written
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      rdata_q <= mem[addr_i];  // sampled before the byte writes land
      for (int k = 0; k < `BRAM_OUT_WE; k++) begin
        if (we_i[k]) begin
          mem[addr_i][k*8 +: 8] <= wdata_i[k*8 +: 8];
        end
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- hw/bram_intrf_translator.sv
`timescale 1ns/100ps
`include "bram_macros.svh"

// splits a word wide port into per bank ports and gathers read data back
// lane 0 sits at the lsb end of the word
module bram_intrf_translator
  import bram_pkg::*;
(
  // word side
  input  logic   en_i,
  input  wbe_t   we_i,
  input  waddr_t addr_i,
  input  word_t  wrdata_i,
  output word_t  rddata_o,

  // bank side, bank b occupies slice b of each vector
  output bank_en_t                                  en_o,
  output logic [`BRAM_BANKS*`BRAM_OUT_WE-1:0]       we_o,
  output logic [`BRAM_BANKS*`BRAM_OUT_ADDR-1:0]     addr_o,
  output logic [`BRAM_BANKS*`BRAM_OUT_WIDTH-1:0]    wrdata_o,
  input  logic [`BRAM_BANKS*`BRAM_OUT_WIDTH-1:0]    rddata_i
);

  localparam int LANES = `BRAM_LANES;
  localparam int DW    = `BRAM_OUT_WIDTH;
  localparam int BW    = `BRAM_OUT_WE;
  localparam int AW    = `BRAM_OUT_ADDR;
  localparam int KW    = `BRAM_BANK_BITS;
  // datum index covers every entry of every bank
  localparam int IDX_W = KW + AW;

  logic [IDX_W-1:0] lane_idx   [LANES];  // word address * lanes + lane
  bank_idx_t        lane_bank  [LANES];  // low index bits
  baddr_t           lane_baddr [LANES];  // high index bits
  bank_en_t         lane_mask  [LANES];  // one hot bank select per lane
  datum_t           lane_wdata [LANES];
  dbe_t             lane_we    [LANES];
  bank_en_t         en_or;

  // per lane index, bank and bank address
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      lane_idx[l]   = IDX_W'(addr_i) * IDX_W'(LANES) + IDX_W'(l);
      lane_bank[l]  = lane_idx[l][KW-1:0];
      lane_baddr[l] = lane_idx[l][KW +: AW];
      lane_mask[l]  = '0;
      lane_mask[l][lane_bank[l]] = 1'b1;
    end
  end

  // a bank is enabled if any lane lands on it
  always_comb begin
    en_or = '0;
    for (int l = 0; l < LANES; l++) begin
      en_or = en_or | lane_mask[l];
    end
  end

  assign en_o = en_i ? en_or : '0;  // nothing selected outside an access

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    assign lane_wdata[l] = wrdata_i[l*DW +: DW];  // word slice for this lane
    assign lane_we[l]    = we_i[l*BW +: BW];
    // pull the datum back from whichever bank this lane hit
    assign rddata_o[l*DW +: DW] = rddata_i[lane_bank[l]*DW +: DW];
  end

  // bank b always serves lane b mod lanes, lanes and banks being powers of two
  for (genvar b = 0; b < `BRAM_BANKS; b++) begin : g_bank_route
    assign addr_o[b*AW +: AW]   = lane_baddr[b % LANES];
    assign wrdata_o[b*DW +: DW] = lane_wdata[b % LANES];
    assign we_o[b*BW +: BW]     = lane_we[b % LANES];
  end

endmodule

//--- hw/bram_port_ctrl.sv
`timescale 1ns/100ps

// single command port controller
// idle -> access (banks enabled) -> resp (done pulsed) -> idle
module bram_port_ctrl
  import bram_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,

  // host side
  input  logic   cmd_valid_i,  // one cycle strobe, dropped while busy
  input  logic   cmd_write_i,
  input  waddr_t cmd_addr_i,
  input  word_t  cmd_wdata_i,
  input  wbe_t   cmd_be_i,
  output logic   busy_o,
  output logic   done_o,
  output word_t  rdata_o,

  // memory side, toward the translator
  output logic   mem_en_o,
  output wbe_t   mem_we_o,
  output waddr_t mem_addr_o,
  output word_t  mem_wdata_o,
  input  word_t  mem_rdata_i
);

  ctrl_state_t state_q, state_d;
  logic        accept;

  // held command
  logic        write_q;
  waddr_t      addr_q;
  word_t       wdata_q;
  wbe_t        be_q;

  assign accept = cmd_valid_i && (state_q == ST_IDLE);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE:   if (accept) state_d = ST_ACCESS;
      ST_ACCESS: state_d = ST_RESP;    // banks sample at the end of this cycle
      ST_RESP:   state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // command capture, address stays put through resp for the read mux
  always_ff @(posedge clk_i) begin
    if (accept) begin
      write_q <= cmd_write_i;
      addr_q  <= cmd_addr_i;
      wdata_q <= cmd_wdata_i;
      be_q    <= cmd_be_i;
    end
  end

  assign busy_o   = (state_q != ST_IDLE);
  assign done_o   = (state_q == ST_RESP);
  assign mem_en_o = (state_q == ST_ACCESS);
  // reads go out with all enables low
  assign mem_we_o    = (mem_en_o && write_q) ? be_q : '0;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = wdata_q;
  assign rdata_o     = mem_rdata_i;  // meaningful only with done after a read

endmodule

//--- hw/bram_banked_top.sv
`timescale 1ns/100ps
`include "bram_macros.svh"

// word wide BRAM port over a set of narrow banks
module bram_banked_top
  import bram_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   cmd_valid_i,
  input  logic   cmd_write_i,
  input  waddr_t cmd_addr_i,
  input  word_t  cmd_wdata_i,
  input  wbe_t   cmd_be_i,
  output logic   busy_o,
  output logic   done_o,
  output word_t  rdata_o
);

  // controller to translator
  logic   mem_en;
  wbe_t   mem_we;
  waddr_t mem_addr;
  word_t  mem_wdata;
  word_t  mem_rdata;

  // translator to banks, slice per bank
  bank_en_t                                bank_en;
  logic [`BRAM_BANKS*`BRAM_OUT_WE-1:0]     bank_we;
  logic [`BRAM_BANKS*`BRAM_OUT_ADDR-1:0]   bank_addr;
  logic [`BRAM_BANKS*`BRAM_OUT_WIDTH-1:0]  bank_wdata;
  logic [`BRAM_BANKS*`BRAM_OUT_WIDTH-1:0]  bank_rdata;

  bram_port_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_write_i (cmd_write_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_wdata_i (cmd_wdata_i),
    .cmd_be_i    (cmd_be_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .rdata_o     (rdata_o),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  bram_intrf_translator u_xlat (
    .en_i     (mem_en),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wrdata_i (mem_wdata),
    .rddata_o (mem_rdata),
    .en_o     (bank_en),
    .we_o     (bank_we),
    .addr_o   (bank_addr),
    .wrdata_o (bank_wdata),
    .rddata_i (bank_rdata)
  );

  for (genvar b = 0; b < `BRAM_BANKS; b++) begin : g_bank
    bram_bank u_bank (
      .clk_i   (clk_i),
      .en_i    (bank_en[b]),
      .we_i    (bank_we[b*`BRAM_OUT_WE +: `BRAM_OUT_WE]),
      .addr_i  (bank_addr[b*`BRAM_OUT_ADDR +: `BRAM_OUT_ADDR]),
      .wdata_i (bank_wdata[b*`BRAM_OUT_WIDTH +: `BRAM_OUT_WIDTH]),
      .rdata_o (bank_rdata[b*`BRAM_OUT_WIDTH +: `BRAM_OUT_WIDTH])
    );
  end

endmodule

//--- bench/bram_banked_chk.sv
`timescale 1ns/100ps
`include "bram_macros.svh"

// protocol rules on the host port and the bank enables
module bram_banked_chk
  import bram_pkg::*;
(
  input logic     clk_i,
  input logic     rst_i,
  input logic     busy_i,
  input logic     done_i,
  input bank_en_t bank_en_i
);

  int unsigned fail_cnt = 0;  // failed assertions so far

  // done is a single cycle pulse
  a_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    done_i |=> !done_i)
    else begin
      fail_cnt++;
      $error("done_o stayed high for two cycles");
    end

  a_done_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    done_i |-> busy_i)  // resp is still a busy state
    else begin
      fail_cnt++;
      $error("done_o high while busy_o low");
    end

  // controller is back in idle one edge after reset is seen
  a_rst_quiet: assert property (@(posedge clk_i)
    rst_i |=> (bank_en_i == '0))
    else begin
      fail_cnt++;
      $error("bank enable set in the cycle after reset");
    end

  // each lane lands on its own bank
  a_lane_banks: assert property (@(posedge clk_i) disable iff (rst_i)
    ($countones(bank_en_i) == 0) || ($countones(bank_en_i) == `BRAM_LANES))
    else begin
      fail_cnt++;
      $error("bank enable count differs from the lane count");
    end

endmodule

bind bram_banked_top bram_banked_chk u_chk (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .busy_i    (busy_o),
  .done_i    (done_o),
  .bank_en_i (bank_en)
);

//--- bench/bram_banked_tb.sv
`timescale 1ns/100ps
`include "bram_macros.svh"

module bram_banked_tb
  import bram_pkg::*;
();

  localparam int LANES  = `BRAM_LANES;
  localparam int DW     = `BRAM_OUT_WIDTH;
  localparam int DBYTES = `BRAM_OUT_WE;
  localparam int WORDS  = 1 << `BRAM_IN_ADDR;  // 512 host words
  localparam int TMO    = 10;                  // cycles allowed for done_o

  logic   clk_i;
  logic   rst_i;
  logic   cmd_valid_i;
  logic   cmd_write_i;
  waddr_t cmd_addr_i;
  word_t  cmd_wdata_i;
  wbe_t   cmd_be_i;
  logic   busy_o;
  logic   done_o;
  word_t  rdata_o;

  datum_t shadow [WORDS*LANES];  // one entry per datum index
  waddr_t used_q [$];            // addresses holding known data
  waddr_t pend_addr;             // read waiting for its done pulse
  logic   read_pending;
  int     done_cnt;

  bram_banked_top DUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_write_i (cmd_write_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_wdata_i (cmd_wdata_i),
    .cmd_be_i    (cmd_be_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .rdata_o     (rdata_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;  // 8 ns period

  // lane l of word a lives at datum index a*lanes + l
  function automatic word_t expected_word(input waddr_t a);
    word_t w;
    for (int l = 0; l < LANES; l++) begin
      w[l*DW +: DW] = shadow[int'(a)*LANES + l];
    end
    return w;
  endfunction

  // byte merge into the shadow, byte k sits in lane k / bytes per datum
  function automatic void apply_write(input waddr_t a, input word_t d, input wbe_t be);
    int idx;
    for (int k = 0; k < `BRAM_IN_WE; k++) begin
      idx = int'(a)*LANES + k / DBYTES;
      if (be[k]) shadow[idx][(k % DBYTES)*8 +: 8] = d[k*8 +: 8];
    end
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("** Error at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  task automatic step();
    @(posedge clk_i);
    #1;  // drive and look just after the edge
  endtask

  // compare process, mid cycle where done_o and rdata_o are stable
  always @(negedge clk_i) begin
    if (rst_i === 1'b0 && done_o === 1'b1) begin
      done_cnt++;
      if (read_pending) begin
        check_word("rdata_o", expected_word(pend_addr), rdata_o);
        read_pending = 1'b0;
      end
    end
  end

  // one command, called 1 ns after an edge with busy_o low
  // poke strobes a write to a neighbour word while busy, it must be dropped
  task automatic run_cmd(input logic wr, input waddr_t a, input word_t d,
                         input wbe_t be, input bit poke);
    int n;
    cmd_valid_i = 1'b1;
    cmd_write_i = wr;
    cmd_addr_i  = a;
    cmd_wdata_i = d;
    cmd_be_i    = be;
    if (wr) begin
      apply_write(a, d, be);
    end else begin
      pend_addr    = a;
      read_pending = 1'b1;
    end
    step();  // edge E takes the strobe
    n = 1;
    cmd_valid_i = 1'b0;
    check_bit("busy_o", 1'b1, busy_o);
    if (poke) begin
      cmd_valid_i = 1'b1;          // held through access and resp
      cmd_write_i = 1'b1;
      cmd_addr_i  = a ^ waddr_t'(1);
      cmd_wdata_i = ~d;
      cmd_be_i    = '1;
    end
    while (done_o !== 1'b1) begin
      if (n >= TMO) stop_on_error("timeout, done_o never rose after a command");
      step();
      n++;
    end
    if (n != 2) stop_on_error($sformatf("done_o came %0d edges after the strobe, not 2", n));
    check_bit("busy_o", 1'b1, busy_o);
    step();
    cmd_valid_i = 1'b0;
    check_bit("done_o", 1'b0, done_o);
    check_bit("busy_o", 1'b0, busy_o);
    if (read_pending) stop_on_error("read data was never compared while done_o was high");
  endtask

  initial begin
    waddr_t a;
    waddr_t b;
    int     dones;
    void'($urandom(32'h1735ea1f));
    done_cnt     = 0;
    read_pending = 1'b0;
    pend_addr    = '0;
    rst_i        = 1'b1;
    cmd_valid_i  = 1'b0;
    cmd_write_i  = 1'b0;
    cmd_addr_i   = '0;
    cmd_wdata_i  = '0;
    cmd_be_i     = '0;
    for (int i = 0; i < 8; i++) step();
    rst_i = 1'b0;

    // 1. quiet after reset
    for (int i = 0; i < 3; i++) begin
      check_bit("busy_o", 1'b0, busy_o);
      check_bit("done_o", 1'b0, done_o);
      step();
    end

    // 2. full words to random addresses, then read back
    for (int i = 0; i < 40; i++) begin
      a = waddr_t'($urandom_range(WORDS-1, 0));
      used_q.push_back(a);
      run_cmd(1'b1, a, word_t'($urandom), '1, 1'b0);
    end
    foreach (used_q[i]) run_cmd(1'b0, used_q[i], '0, '0, 1'b0);

    // 3. random byte enables merge over the older data
    for (int i = 0; i < 40; i++) begin
      a = used_q[$urandom_range(used_q.size()-1, 0)];
      run_cmd(1'b1, a, word_t'($urandom), wbe_t'($urandom), 1'b0);
      run_cmd(1'b0, a, '0, '0, 1'b0);
    end

    // 4. distinct pattern in every word, catches lane aliasing
    for (int i = 0; i < WORDS; i++) begin
      a = waddr_t'(i);
      run_cmd(1'b1, a, word_t'({4'hc, 3'b000, a, 4'h3, 3'b000, a}), '1, 1'b0);
    end
    for (int i = 0; i < WORDS; i++) run_cmd(1'b0, waddr_t'(i), '0, '0, 1'b0);

    // 5. strobes while busy are dropped
    a     = waddr_t'(9'h0a6);
    b     = a ^ waddr_t'(1);
    dones = done_cnt;
    run_cmd(1'b1, a, 32'h5aa5_c33c, '1, 1'b1);
    for (int i = 0; i < 4; i++) begin
      check_bit("done_o", 1'b0, done_o);
      check_bit("busy_o", 1'b0, busy_o);
      step();
    end
    if (done_cnt != dones + 1) stop_on_error("a strobe sent while busy produced an extra done_o");
    run_cmd(1'b0, a, '0, '0, 1'b0);
    run_cmd(1'b0, b, '0, '0, 1'b0);  // neighbour keeps its pattern

    // 6. reset in the middle of a read, memory survives
    a = waddr_t'(9'h133);
    run_cmd(1'b1, a, 32'hdead_0ff1, '1, 1'b0);
    cmd_valid_i = 1'b1;
    cmd_write_i = 1'b0;
    cmd_addr_i  = a;
    step();
    cmd_valid_i = 1'b0;
    rst_i       = 1'b1;
    for (int i = 0; i < 3; i++) begin
      step();
      check_bit("busy_o", 1'b0, busy_o);
      check_bit("done_o", 1'b0, done_o);
    end
    rst_i = 1'b0;
    step();
    run_cmd(1'b0, a, '0, '0, 1'b0);
    run_cmd(1'b0, used_q[0], '0, '0, 1'b0);

    // bound checker counts its own assertion failures
    if (DUT.u_chk.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("protocol assertions failed %0d times", DUT.u_chk.fail_cnt);
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+hw
hw/bram_pkg.sv
hw/bram_bank.sv
hw/bram_intrf_translator.sv
hw/bram_port_ctrl.sv
hw/bram_banked_top.sv
bench/bram_banked_chk.sv
bench/bram_banked_tb.sv

//--- Makefile
# Verilator build and run for the banked BRAM testbench

VERILATOR ?= verilator
TOP       ?= bram_banked_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# verdict comes from the printed output only
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
